// File: source/heapGeometryPkg.sv
// Heap geometry package
// Sizes of the array heap and the width types built on them

package heapGeometryPkg;

  //------------------------------------------------------------
  // Memory shape
  //------------------------------------------------------------

  localparam int addressBits = 2;                     // Bits in an array number
  localparam int indexBits   = 3;                     // Bits in an element index
  localparam int dataBits    = 12;                    // Width of one element

  localparam int arrayCount  = 2 ** addressBits;      // Arrays in the heap
  localparam int arrayLength = 2 ** indexBits;        // Elements per array

  //------------------------------------------------------------
  // Width types
  //------------------------------------------------------------

  // Array number
  typedef logic [addressBits-1:0] arrayIdT;

  // Element index within one array
  typedef logic [indexBits-1:0] indexT;

  // One extra bit so a full array fits
  typedef logic [indexBits:0] sizeT;

  // Element value
  typedef logic [dataBits-1:0] dataT;

endpackage

// File: source/heapOpsPkg.sv
// Heap operations package
// Caller opcodes, error codes, element store actions and the
// request, checked request and response structs

package heapOpsPkg;

  localparam int opcodeBits = 4;                      // Caller opcode width
  localparam int errorBits  = 3;                      // Error code width
  localparam int actionBits = 3;                      // Store action width

  //------------------------------------------------------------
  // Caller operations
  //------------------------------------------------------------

  typedef enum logic [opcodeBits-1:0] {
    opClear    = 4'd0,                                // Empty the whole heap
    opAlloc    = 4'd1,                                // Get a fresh or reused array
    opFree     = 4'd2,                                // Return an array
    opWrite    = 4'd3,                                // Store an element
    opRead     = 4'd4,                                // Fetch an element
    opSize     = 4'd5,                                // Current array size
    opPush     = 4'd6,                                // Append at the end
    opPop      = 4'd7,                                // Remove from the end
    opAdd      = 4'd8,                                // Add, new value back
    opAddAfter = 4'd9,                                // Add, old value back
    opSubtract = 4'd10,                               // Subtract, new value back
    opSubAfter = 4'd11                                // Subtract, old value back
  } opcodeT;

  //------------------------------------------------------------
  // Error codes
  //------------------------------------------------------------

  typedef enum logic [errorBits-1:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,                           // Never handed out
    errFreed        = 3'd2,                           // Handed out, then freed
    errOutOfBounds  = 3'd3,                           // Index at or past size
    errEmpty        = 3'd4,                           // Pop with nothing left
    errFull         = 3'd5,                           // Push past arrayLength
    errOutOfMemory  = 3'd6,                           // No array left to give
    errDoubleFree   = 3'd7                            // Free of a freed array
  } errorT;

  //------------------------------------------------------------
  // Work for the element store
  //------------------------------------------------------------

  typedef enum logic [actionBits-1:0] {
    actIdle   = 3'd0,                                 // Zero data, error echoed
    actPass   = 3'd1,                                 // Return data field as is
    actWrite  = 3'd2,
    actRead   = 3'd3,
    actAddNew = 3'd4,
    actAddOld = 3'd5,
    actSubNew = 3'd6,
    actSubOld = 3'd7
  } storeActionT;

  //------------------------------------------------------------
  // Structs between caller, stages and response
  //------------------------------------------------------------

  typedef struct packed {
    opcodeT                   opcode;
    heapGeometryPkg::arrayIdT array;
    heapGeometryPkg::indexT   index;
    heapGeometryPkg::dataT    data;
  } heapRequestT;

  typedef struct packed {
    storeActionT              action;
    heapGeometryPkg::arrayIdT array;
    heapGeometryPkg::indexT   index;                  // Resolved element index
    heapGeometryPkg::dataT    data;
    errorT                    error;
  } checkedRequestT;

  typedef struct packed {
    heapGeometryPkg::dataT data;
    errorT                 error;
  } heapResponseT;

endpackage

// File: source/heapBookkeeper.sv
// Heap bookkeeper, first pipeline stage
// Owns allocation bits, free stack and array sizes, checks each
// request and tells the element store what to do

`timescale 1ns/1ps

module heapBookkeeper (
  input  logic                       clock,
  input  logic                       resetN,
  input  logic                       requestValid,
  input  heapOpsPkg::heapRequestT    request,
  output logic                       checkedValid,
  output heapOpsPkg::checkedRequestT checked
);

  localparam int addressBits = heapGeometryPkg::addressBits;
  localparam int arrayCount  = heapGeometryPkg::arrayCount;

  //------------------------------------------------------------
  // Bookkeeping state
  //------------------------------------------------------------

  logic [arrayCount-1:0]    allocated;                // One bit per array
  logic [addressBits:0]     issuedCount;              // Arrays ever handed out
  logic [addressBits:0]     freeTop;                  // Free stack depth
  heapGeometryPkg::arrayIdT freeStack [arrayCount];   // Freed array numbers, LIFO
  heapGeometryPkg::sizeT    sizes [arrayCount];

  // Decode results
  heapOpsPkg::checkedRequestT decoded;
  heapGeometryPkg::sizeT      curSize;
  heapGeometryPkg::arrayIdT   allocId;
  heapGeometryPkg::arrayIdT   stackTopId;
  heapGeometryPkg::arrayIdT   sizeArray;
  heapGeometryPkg::sizeT      sizeNext;
  logic                       neverIssued;
  logic                       isFreed;
  logic                       indexOutside;
  logic                       sizeWrite;
  logic                       doAlloc;
  logic                       takeFresh;
  logic                       popFree;
  logic                       doFree;
  logic                       doClear;

  assign curSize      = sizes[request.array];
  assign neverIssued  = {1'b0, request.array} >= issuedCount;
  assign isFreed      = !allocated[request.array];
  assign indexOutside = {1'b0, request.index} >= curSize;
  assign stackTopId   = heapGeometryPkg::arrayIdT'(freeTop - 1'b1);

  //------------------------------------------------------------
  // Request check and store-action decode
  //------------------------------------------------------------

  always_comb begin
    decoded.action = heapOpsPkg::actIdle;
    decoded.array  = request.array;
    decoded.index  = request.index;
    decoded.data   = request.data;
    decoded.error  = heapOpsPkg::errNone;
    allocId        = issuedCount[addressBits-1:0];
    sizeArray      = request.array;
    sizeNext       = curSize;
    sizeWrite      = 1'b0;
    doAlloc        = 1'b0;
    takeFresh      = 1'b0;
    popFree        = 1'b0;
    doFree         = 1'b0;
    doClear        = 1'b0;

    case (request.opcode)
      heapOpsPkg::opClear: begin
        doClear = 1'b1;
      end
      heapOpsPkg::opAlloc: begin
        if (freeTop != '0) begin                      // Reuse the last freed array
          allocId = freeStack[stackTopId];
          popFree = 1'b1;
        end else if (issuedCount < (addressBits + 1)'(arrayCount)) begin
          takeFresh = 1'b1;
        end
        if (popFree || takeFresh) begin
          doAlloc        = 1'b1;
          sizeWrite      = 1'b1;                      // New array starts empty
          sizeArray      = allocId;
          sizeNext       = '0;
          decoded.action = heapOpsPkg::actPass;
          decoded.array  = allocId;
          decoded.data   = heapGeometryPkg::dataT'(allocId);
        end else begin
          decoded.error = heapOpsPkg::errOutOfMemory;
        end
      end
      heapOpsPkg::opFree: begin
        if (neverIssued) decoded.error = heapOpsPkg::errNotAllocated;
        else if (isFreed) decoded.error = heapOpsPkg::errDoubleFree;
        else doFree = 1'b1;
      end
      default: begin
        if (neverIssued) begin
          decoded.error = heapOpsPkg::errNotAllocated;
        end else if (isFreed) begin
          decoded.error = heapOpsPkg::errFreed;
        end else begin
          case (request.opcode)
            heapOpsPkg::opWrite: begin
              decoded.action = heapOpsPkg::actWrite;
              if (indexOutside) begin                 // Grow to cover the index
                sizeWrite = 1'b1;
                sizeNext  = {1'b0, request.index} + 1'b1;
              end
            end
            heapOpsPkg::opSize: begin
              decoded.action = heapOpsPkg::actPass;
              decoded.data   = heapGeometryPkg::dataT'(curSize);
            end
            heapOpsPkg::opPush: begin
              if (curSize == heapGeometryPkg::sizeT'(heapGeometryPkg::arrayLength)) begin
                decoded.error = heapOpsPkg::errFull;
              end else begin
                decoded.action = heapOpsPkg::actWrite;
                decoded.index  = curSize[heapGeometryPkg::indexBits-1:0];
                sizeWrite      = 1'b1;
                sizeNext       = curSize + 1'b1;
              end
            end
            heapOpsPkg::opPop: begin
              if (curSize == '0) begin
                decoded.error = heapOpsPkg::errEmpty;
              end else begin
                sizeWrite      = 1'b1;
                sizeNext       = curSize - 1'b1;
                decoded.action = heapOpsPkg::actRead;
                decoded.index  = sizeNext[heapGeometryPkg::indexBits-1:0];
              end
            end
            heapOpsPkg::opRead, heapOpsPkg::opAdd, heapOpsPkg::opAddAfter,
            heapOpsPkg::opSubtract, heapOpsPkg::opSubAfter: begin
              if (indexOutside) begin
                decoded.error = heapOpsPkg::errOutOfBounds;
              end else begin
                case (request.opcode)
                  heapOpsPkg::opAdd:      decoded.action = heapOpsPkg::actAddNew;
                  heapOpsPkg::opAddAfter: decoded.action = heapOpsPkg::actAddOld;
                  heapOpsPkg::opSubtract: decoded.action = heapOpsPkg::actSubNew;
                  heapOpsPkg::opSubAfter: decoded.action = heapOpsPkg::actSubOld;
                  default:                decoded.action = heapOpsPkg::actRead;
                endcase
              end
            end
            default: ;                                // Unused encodings do nothing
          endcase
        end
      end
    endcase
  end

  //------------------------------------------------------------
  // Control state, updated on the accepting edge
  //------------------------------------------------------------

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated    <= '0;
      issuedCount  <= '0;
      freeTop      <= '0;
      checkedValid <= 1'b0;
    end else begin
      checkedValid <= requestValid;
      if (requestValid) begin
        if (doClear) begin
          allocated   <= '0;
          issuedCount <= '0;
          freeTop     <= '0;
        end else begin
          if (doAlloc) allocated[allocId] <= 1'b1;
          if (doFree) allocated[request.array] <= 1'b0;  // No longer live
          if (takeFresh) issuedCount <= issuedCount + 1'b1;
          if (popFree) freeTop <= freeTop - 1'b1;
          else if (doFree) freeTop <= freeTop + 1'b1;
        end
      end
    end
  end

  // Sizes, free stack contents and the stage output
  always_ff @(posedge clock) begin
    if (requestValid) begin
      checked <= decoded;
      if (sizeWrite) sizes[sizeArray] <= sizeNext;
      if (doFree) freeStack[freeTop[addressBits-1:0]] <= request.array;
    end
  end

  //------------------------------------------------------------
  // Checks
  //------------------------------------------------------------

  freeStackBound: assert property (@(posedge clock) disable iff (!resetN)
    freeTop <= (addressBits + 1)'(arrayCount));

  actionWithoutError: assert property (@(posedge clock) disable iff (!resetN)
    checkedValid && checked.action != heapOpsPkg::actIdle |->
      checked.error == heapOpsPkg::errNone);

endmodule

// File: source/heapElementStore.sv
// Heap element store, second pipeline stage
// Holds every element and performs write, read and read-modify-write,
// then forms the caller response

`timescale 1ns/1ps

module heapElementStore (
  input  logic                       clock,
  input  logic                       resetN,
  input  logic                       checkedValid,
  input  heapOpsPkg::checkedRequestT checked,
  output logic                       responseValid,
  output heapOpsPkg::heapResponseT   response
);

  //------------------------------------------------------------
  // Element array
  //------------------------------------------------------------

  heapGeometryPkg::dataT elements [heapGeometryPkg::arrayCount][heapGeometryPkg::arrayLength];

  heapGeometryPkg::dataT oldValue;                    // Element before this access
  heapGeometryPkg::dataT sumValue;
  heapGeometryPkg::dataT diffValue;
  heapGeometryPkg::dataT newValue;                    // Value to store back
  heapGeometryPkg::dataT resultValue;                 // Value to return
  logic                  storeEnable;

  assign oldValue  = elements[checked.array][checked.index];
  assign sumValue  = oldValue + checked.data;         // Wraps modulo 2**dataBits
  assign diffValue = oldValue - checked.data;

  //------------------------------------------------------------
  // Action decode
  //------------------------------------------------------------

  always_comb begin
    storeEnable = 1'b0;
    newValue    = oldValue;
    resultValue = '0;
    case (checked.action)
      heapOpsPkg::actPass: begin
        resultValue = checked.data;                   // Alloc number or size
      end
      heapOpsPkg::actWrite: begin
        storeEnable = 1'b1;
        newValue    = checked.data;
        resultValue = checked.data;
      end
      heapOpsPkg::actRead: begin
        resultValue = oldValue;
      end
      heapOpsPkg::actAddNew: begin
        storeEnable = 1'b1;
        newValue    = sumValue;
        resultValue = sumValue;
      end
      heapOpsPkg::actAddOld: begin
        storeEnable = 1'b1;
        newValue    = sumValue;
        resultValue = oldValue;
      end
      heapOpsPkg::actSubNew: begin
        storeEnable = 1'b1;
        newValue    = diffValue;
        resultValue = diffValue;
      end
      heapOpsPkg::actSubOld: begin
        storeEnable = 1'b1;
        newValue    = diffValue;
        resultValue = oldValue;
      end
      default: ;                                      // Idle returns zero
    endcase
  end

  //------------------------------------------------------------
  // Store update and response
  //------------------------------------------------------------

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      responseValid <= 1'b0;
    end else begin
      responseValid <= checkedValid;
    end
  end

  // Whole read-modify-write in one edge
  always_ff @(posedge clock) begin
    if (checkedValid) begin
      if (storeEnable) elements[checked.array][checked.index] <= newValue;
      response.data  <= resultValue;
      response.error <= checked.error;                // Bookkeeper's verdict
    end
  end

  stageTiming: assert property (@(posedge clock) disable iff (!resetN)
    responseValid == $past(checkedValid));

endmodule

// File: source/heapMemory.sv
// Array heap top level
// Bookkeeping stage followed by the element store, two cycles
// from accepted request to response

`timescale 1ns/1ps

module heapMemory (
  input  logic                     clock,
  input  logic                     resetN,
  input  logic                     requestValid,
  input  heapOpsPkg::heapRequestT  request,
  output logic                     responseValid,
  output heapOpsPkg::heapResponseT response
);

  //------------------------------------------------------------
  // Stage one to stage two
  //------------------------------------------------------------

  logic                       checkedValid;          // Item present this cycle
  heapOpsPkg::checkedRequestT checked;               // Action, target and error

  heapBookkeeper heapBookkeeper_inst (
    .clock        (clock),
    .resetN       (resetN),
    .requestValid (requestValid),
    .request      (request),
    .checkedValid (checkedValid),
    .checked      (checked)
  );

  heapElementStore heapElementStore_inst (
    .clock         (clock),
    .resetN        (resetN),
    .checkedValid  (checkedValid),
    .checked       (checked),
    .responseValid (responseValid),
    .response      (response)
  );

endmodule

// File: test/heapMemoryTest.sv
// Array heap testbench
// Drives heapMemory through allocation, access checks, write and read,
// push and pop and arithmetic, with a reference model feeding the checks

`timescale 1ns/1ps

module heapMemoryTest;

  localparam int arrayCount  = heapGeometryPkg::arrayCount;
  localparam int arrayLength = heapGeometryPkg::arrayLength;

  // Most requests each test can issue
  localparam int allocRequests  = 10;
  localparam int accessRequests = 14;
  localparam int writeRequests  = 21;
  localparam int pushRequests   = 38;
  localparam int arithRequests  = 38;
  localparam int totalRequests  = allocRequests + accessRequests + writeRequests +
                                  pushRequests + arithRequests;
  localparam int resetCycles    = 16;
  localparam int cycleLimit     = 2 * totalRequests + resetCycles + 50;

  logic                     clock;
  logic                     resetN;
  logic                     requestValid;
  heapOpsPkg::heapRequestT  request;
  logic                     responseValid;
  heapOpsPkg::heapResponseT response;

  integer seed;
  int     cycleCount;
  int     errorCount;
  int     testErrorsBefore;
  int     testsPassed;
  int     testsFailed;
  string  currentTest;

  heapOpsPkg::heapResponseT expectQueue [$];          // Oldest request first
  string                    nameQueue [$];
  heapOpsPkg::heapResponseT expectedResponse;         // For the response due now
  string                    expectedName;

  //------------------------------------------------------------
  // Reference model state
  //------------------------------------------------------------

  bit [arrayCount-1:0]   modelAllocated;
  int                    nextFresh;                    // Arrays ever handed out
  int                    freeList [$];                 // LIFO of freed numbers
  int                    modelSize [arrayCount];
  heapGeometryPkg::dataT modelElement [arrayCount][arrayLength];

  heapMemory heapMemory_inst (
    .clock         (clock),
    .resetN        (resetN),
    .requestValid  (requestValid),
    .request       (request),
    .responseValid (responseValid),
    .response      (response)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  //------------------------------------------------------------
  // Checks
  //------------------------------------------------------------

  responseOnTime: assert property (@(posedge clock) disable iff (!resetN)
    requestValid |-> ##2 responseValid)
    else reportProblem("no response two cycles after a request");

  noStrayResponse: assert property (@(posedge clock) disable iff (!resetN)
    responseValid |-> $past(requestValid, 2))
    else reportProblem("response without a request two cycles before");

  responseMatches: assert property (@(posedge clock) disable iff (!resetN)
    responseValid |-> response == expectedResponse)
    else reportMismatch($sampled(response));

  // Line up the expectation for the response that is compared next
  always @(negedge clock) begin
    if (responseValid) begin
      if (expectQueue.size() == 0) begin
        reportProblem("a response arrived while no request was waiting");
      end else begin
        expectedResponse = expectQueue.pop_front();
        expectedName     = nameQueue.pop_front();
      end
    end
  end

  always @(posedge clock) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic reportMismatch(input heapOpsPkg::heapResponseT actual);
    errorCount++;
    $display("Fail %s expected data %h error %0d actual data %h error %0d",
      expectedName, expectedResponse.data, expectedResponse.error, actual.data, actual.error);
  endtask

  task automatic reportProblem(input string what);
    errorCount++;
    $display("Error in %s: %s", currentTest, what);
  endtask

  //------------------------------------------------------------
  // Reference model, one request at a time
  //------------------------------------------------------------

  task automatic predictResponse(input heapOpsPkg::heapRequestT req,
                                 output heapOpsPkg::heapResponseT expected);
    int                    arr;
    int                    idx;
    heapGeometryPkg::dataT oldValue;
    arr = int'(req.array);
    idx = int'(req.index);
    expected.data  = '0;
    expected.error = heapOpsPkg::errNone;
    oldValue       = modelElement[arr][idx];
    case (req.opcode)
      heapOpsPkg::opClear: begin
        modelAllocated = '0;
        nextFresh      = 0;
        freeList.delete();
      end
      heapOpsPkg::opAlloc: begin
        if (freeList.size() != 0) begin
          arr = freeList.pop_back();                   // Last freed comes back first
        end else if (nextFresh < arrayCount) begin
          arr = nextFresh;
          nextFresh++;
        end else begin
          arr = -1;
        end
        if (arr < 0) begin
          expected.error = heapOpsPkg::errOutOfMemory;
        end else begin
          modelAllocated[arr] = 1'b1;
          modelSize[arr]      = 0;
          expected.data       = heapGeometryPkg::dataT'(arr);
        end
      end
      heapOpsPkg::opFree: begin
        if (arr >= nextFresh) expected.error = heapOpsPkg::errNotAllocated;
        else if (!modelAllocated[arr]) expected.error = heapOpsPkg::errDoubleFree;
        else begin
          modelAllocated[arr] = 1'b0;
          freeList.push_back(arr);
        end
      end
      default: begin
        if (arr >= nextFresh) expected.error = heapOpsPkg::errNotAllocated;
        else if (!modelAllocated[arr]) expected.error = heapOpsPkg::errFreed;
        else begin
          case (req.opcode)
            heapOpsPkg::opWrite: begin
              modelElement[arr][idx] = req.data;
              if (idx >= modelSize[arr]) modelSize[arr] = idx + 1;
              expected.data = req.data;
            end
            heapOpsPkg::opSize: expected.data = heapGeometryPkg::dataT'(modelSize[arr]);
            heapOpsPkg::opPush: begin
              if (modelSize[arr] == arrayLength) begin
                expected.error = heapOpsPkg::errFull;
              end else begin
                modelElement[arr][modelSize[arr]] = req.data;
                modelSize[arr]++;
                expected.data = req.data;
              end
            end
            heapOpsPkg::opPop: begin
              if (modelSize[arr] == 0) begin
                expected.error = heapOpsPkg::errEmpty;
              end else begin
                modelSize[arr]--;
                expected.data = modelElement[arr][modelSize[arr]];
              end
            end
            default: begin
              if (idx >= modelSize[arr]) begin
                expected.error = heapOpsPkg::errOutOfBounds;
              end else begin
                case (req.opcode)
                  heapOpsPkg::opAdd, heapOpsPkg::opAddAfter:
                    modelElement[arr][idx] = oldValue + req.data;   // Wraps at 12 bits
                  heapOpsPkg::opSubtract, heapOpsPkg::opSubAfter:
                    modelElement[arr][idx] = oldValue - req.data;
                  default: ;
                endcase
                if (req.opcode == heapOpsPkg::opAdd || req.opcode == heapOpsPkg::opSubtract)
                  expected.data = modelElement[arr][idx];
                else
                  expected.data = oldValue;                         // Read and the After ops
              end
            end
          endcase
        end
      end
    endcase
  endtask

  //------------------------------------------------------------
  // Stimulus helpers
  //------------------------------------------------------------

  function automatic heapGeometryPkg::dataT randomData();
    return heapGeometryPkg::dataT'($random(seed));
  endfunction

  task automatic sendRequest(input heapOpsPkg::opcodeT op, input int arr, input int idx,
                             input heapGeometryPkg::dataT value);
    heapOpsPkg::heapRequestT  req;
    heapOpsPkg::heapResponseT expected;
    req.opcode = op;
    req.array  = heapGeometryPkg::arrayIdT'(arr);
    req.index  = heapGeometryPkg::indexT'(idx);
    req.data   = value;
    predictResponse(req, expected);
    @(negedge clock);
    request      = req;
    requestValid = 1'b1;
    expectQueue.push_back(expected);
    nameQueue.push_back(currentTest);
  endtask

  // Stop requesting and wait until every response has been compared
  task automatic drainPipeline();
    @(negedge clock);
    requestValid = 1'b0;
    do @(posedge clock); while (expectQueue.size() != 0);
    @(negedge clock);
  endtask

  task automatic beginTest(input string name);
    currentTest      = name;
    testErrorsBefore = errorCount;
  endtask

  task automatic endTest();
    drainPipeline();
    if (errorCount == testErrorsBefore) begin
      testsPassed++;
      $display("%s: passed", currentTest);
    end else begin
      testsFailed++;
      $display("%s: failed with %0d errors", currentTest, errorCount - testErrorsBefore);
    end
  endtask

  //------------------------------------------------------------
  // Tests
  //------------------------------------------------------------

  task automatic allocationOrder();
    beginTest("allocation order");
    sendRequest(heapOpsPkg::opClear, 0, 0, '0);
    repeat (arrayCount + 1) sendRequest(heapOpsPkg::opAlloc, 0, 0, '0);   // Last one runs out
    sendRequest(heapOpsPkg::opFree, 1, 0, '0);
    sendRequest(heapOpsPkg::opFree, 2, 0, '0);
    repeat (2) sendRequest(heapOpsPkg::opAlloc, 0, 0, '0);
    endTest();
  endtask

  task automatic accessErrors();
    beginTest("access errors");
    sendRequest(heapOpsPkg::opClear, 0, 0, '0);
    sendRequest(heapOpsPkg::opAlloc, 0, 0, '0);
    sendRequest(heapOpsPkg::opAlloc, 0, 0, '0);
    sendRequest(heapOpsPkg::opRead, 2, 0, '0);                      // Never handed out
    sendRequest(heapOpsPkg::opWrite, 3, 1, randomData());
    sendRequest(heapOpsPkg::opFree, 3, 0, '0);
    sendRequest(heapOpsPkg::opFree, 1, 0, '0);
    sendRequest(heapOpsPkg::opRead, 1, 0, '0);                      // Freed
    sendRequest(heapOpsPkg::opPush, 1, 0, randomData());
    sendRequest(heapOpsPkg::opFree, 1, 0, '0);                      // Second free
    sendRequest(heapOpsPkg::opWrite, 0, 2, randomData());
    sendRequest(heapOpsPkg::opRead, 0, 3, '0);                      // At the size
    sendRequest(heapOpsPkg::opAddAfter, 0, 7, randomData());
    sendRequest(heapOpsPkg::opRead, 0, 2, '0);
    endTest();
  endtask

  task automatic writeReadSize();
    logic [arrayLength-1:0] written;
    int                     idx;
    beginTest("write read size");
    written = '0;
    sendRequest(heapOpsPkg::opClear, 0, 0, '0);
    sendRequest(heapOpsPkg::opAlloc, 0, 0, '0);
    repeat (10) begin                                  // Back to back writes
      idx = int'($random(seed) & 32'd7);
      written[idx] = 1'b1;
      sendRequest(heapOpsPkg::opWrite, 0, idx, randomData());
    end
    sendRequest(heapOpsPkg::opSize, 0, 0, '0);
    for (int i = 0; i < arrayLength; i++) begin
      if (written[i]) sendRequest(heapOpsPkg::opRead, 0, i, '0);
    end
    endTest();
  endtask

  task automatic pushPop();
    beginTest("push and pop");
    sendRequest(heapOpsPkg::opClear, 0, 0, '0);
    sendRequest(heapOpsPkg::opAlloc, 0, 0, '0);
    sendRequest(heapOpsPkg::opPop, 0, 0, '0);                       // Nothing to pop yet
    sendRequest(heapOpsPkg::opSize, 0, 0, '0);
    repeat (arrayLength) begin
      sendRequest(heapOpsPkg::opPush, 0, 0, randomData());
      sendRequest(heapOpsPkg::opSize, 0, 0, '0);
    end
    sendRequest(heapOpsPkg::opPush, 0, 0, randomData());            // Already full
    repeat (arrayLength) begin
      sendRequest(heapOpsPkg::opPop, 0, 0, '0);
      sendRequest(heapOpsPkg::opSize, 0, 0, '0);
    end
    sendRequest(heapOpsPkg::opPop, 0, 0, '0);
    endTest();
  endtask

  task automatic arithmetic();
    beginTest("arithmetic");
    sendRequest(heapOpsPkg::opClear, 0, 0, '0);
    sendRequest(heapOpsPkg::opAlloc, 0, 0, '0);
    for (int i = 0; i < 4; i++) sendRequest(heapOpsPkg::opWrite, 0, i, randomData());
    for (int i = 0; i < 4; i++) begin                  // Each read follows in the next cycle
      sendRequest(heapOpsPkg::opAdd, 0, i, randomData());
      sendRequest(heapOpsPkg::opRead, 0, i, '0);
      sendRequest(heapOpsPkg::opAddAfter, 0, i, randomData());
      sendRequest(heapOpsPkg::opRead, 0, i, '0);
      sendRequest(heapOpsPkg::opSubtract, 0, i, randomData());
      sendRequest(heapOpsPkg::opRead, 0, i, '0);
      sendRequest(heapOpsPkg::opSubAfter, 0, i, randomData());
      sendRequest(heapOpsPkg::opRead, 0, i, '0);
    end
    endTest();
  endtask

  initial begin
    seed             = 32'hb495_10f6;
    resetN           = 1'b0;
    requestValid     = 1'b0;
    request          = '0;
    cycleCount       = 0;
    errorCount       = 0;
    testsPassed      = 0;
    testsFailed      = 0;
    currentTest      = "reset";
    expectedResponse = '0;
    expectedName     = "";
    modelAllocated   = '0;
    nextFresh        = 0;
    for (int a = 0; a < arrayCount; a++) begin
      modelSize[a] = 0;
      for (int e = 0; e < arrayLength; e++) modelElement[a][e] = '0;
    end
    repeat (resetCycles) @(negedge clock);
    resetN = 1'b1;
    allocationOrder();
    accessErrors();
    writeReadSize();
    pushPop();
    arithmetic();
    $display("Tests passed %0d, failed %0d", testsPassed, testsFailed);
    if (errorCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: heapMemory.f
source/heapGeometryPkg.sv
source/heapOpsPkg.sv
source/heapBookkeeper.sv
source/heapElementStore.sv
source/heapMemory.sv
test/heapMemoryTest.sv
